// ==== src/exec_pkg.sv ====
////////////////////////////////////////////////////////////
// Shared widths, selector codes and stage structs for the
// three-stage operand path. Immediates arrive sign-extended.
// Shifts take only the low 5 bits of operand B
////////////////////////////////////////////////////////////

package exec_pkg;

	////////////////////////////////////////////////////////////
	// Widths and sizes
	////////////////////////////////////////////////////////////
	localparam int DATA_W    = 32;
	localparam int REG_IDX_W = 5;
	localparam int NUM_REGS  = 32;
	localparam int SEL_W     = 2;
	localparam int ALU_OP_W  = 3;
	// Shift amount taken from operand B
	localparam int SHAMT_W   = 5;

	typedef logic [DATA_W-1:0]    operand_t;
	typedef logic [REG_IDX_W-1:0] reg_idx_t;
	typedef logic [SEL_W-1:0]     sel_t;

	////////////////////////////////////////////////////////////
	// Operand source selectors
	////////////////////////////////////////////////////////////
	localparam sel_t SEL_RF      = 2'd0;
	// Immediate is only meaningful on operand B
	localparam sel_t SEL_IMM     = 2'd1;
	localparam sel_t SEL_EX_FORW = 2'd2;
	localparam sel_t SEL_WB_FORW = 2'd3;

	// ALU operations, code 7 unused
	typedef enum logic [ALU_OP_W-1:0] {
		ALU_ADD = 3'd0,
		ALU_SUB = 3'd1,
		ALU_AND = 3'd2,
		ALU_OR  = 3'd3,
		ALU_XOR = 3'd4,
		ALU_SLL = 3'd5,
		ALU_SRL = 3'd6
	} alu_op_e;

	////////////////////////////////////////////////////////////
	// Stage structs
	////////////////////////////////////////////////////////////
	// Decoded instruction presented to ID
	typedef struct packed {
		logic     valid;
		alu_op_e  op;
		reg_idx_t rd;
		reg_idx_t ra;
		reg_idx_t rb;
		logic     use_imm;
		operand_t imm;
	} issue_t;

	// EX destination as seen by forwarding control
	typedef struct packed {
		logic     valid;
		reg_idx_t rd;
	} ex_dst_t;

	// WB state, register file write and retire port in one
	typedef struct packed {
		logic     valid;
		reg_idx_t rd;
		operand_t data;
	} wb_t;

endpackage

// ==== src/reg_file.sv ====
////////////////////////////////////////////////////////////
// 32 x 32 register file, two async reads, one sync write.
// r0 reads zero and ignores writes. Write data is visible
// on the read ports only after the write edge
////////////////////////////////////////////////////////////

module reg_file (
	input  logic              clk,
	input  logic              rst_n,
	input  exec_pkg::reg_idx_t ra,
	input  exec_pkg::reg_idx_t rb,
	output exec_pkg::operand_t rf_a,
	output exec_pkg::operand_t rf_b,
	input  exec_pkg::wb_t      wb
);

	// Register storage
	exec_pkg::operand_t regs [exec_pkg::NUM_REGS];

	////////////////////////////////////////////////////////////
	// Write port
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			// All registers start at zero
			for (int i = 0; i < exec_pkg::NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wb.valid && (wb.rd != '0)) begin
			// Drop writes aimed at r0
			regs[wb.rd] <= wb.data;
		end
	end

	////////////////////////////////////////////////////////////
	// Read ports
	////////////////////////////////////////////////////////////
	// r0 forced to zero on read
	always_comb begin
		rf_a = (ra == '0) ? '0 : regs[ra];
		rf_b = (rb == '0) ? '0 : regs[rb];
	end

endmodule

// ==== src/fwd_ctrl.sv ====
////////////////////////////////////////////////////////////
// Operand source selection for the instruction in ID.
// EX wins over WB, WB over the register file.
// r0 is never forwarded. Purely combinational
////////////////////////////////////////////////////////////

module fwd_ctrl (
	input  exec_pkg::issue_t  issue,
	input  exec_pkg::ex_dst_t ex_dst,
	input  exec_pkg::wb_t     wb,
	output exec_pkg::sel_t    sel_a,
	output exec_pkg::sel_t    sel_b
);

	// Picks the newest producer of one source register
	function automatic exec_pkg::sel_t pick_src(
		input exec_pkg::reg_idx_t src,
		input exec_pkg::ex_dst_t  ex,
		input exec_pkg::wb_t      w
	);
		exec_pkg::sel_t sel;
		sel = exec_pkg::SEL_RF;
		if (src != '0) begin
			// Youngest result first
			if (ex.valid && (ex.rd == src)) begin
				sel = exec_pkg::SEL_EX_FORW;
			end else if (w.valid && (w.rd == src)) begin
				sel = exec_pkg::SEL_WB_FORW;
			end
		end
		return sel;
	endfunction

	////////////////////////////////////////////////////////////
	// Selectors
	////////////////////////////////////////////////////////////
	always_comb begin
		// Operand A never takes the immediate
		sel_a = pick_src(issue.ra, ex_dst, wb);
		// Immediate overrides any match on rb
		if (issue.use_imm) begin
			sel_b = exec_pkg::SEL_IMM;
		end else begin
			sel_b = pick_src(issue.rb, ex_dst, wb);
		end
	end

endmodule

// ==== src/operand_muxes.sv ====
////////////////////////////////////////////////////////////
// Operand forwarding muxes and EX operand registers.
// On the first ID freeze edge the operand is captured and
// kept until the release edge, which does not reload it
////////////////////////////////////////////////////////////

module operand_muxes (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               id_freeze,
	input  logic               ex_freeze,
	input  exec_pkg::operand_t rf_a,
	input  exec_pkg::operand_t rf_b,
	input  exec_pkg::operand_t ex_forw,
	input  exec_pkg::operand_t wb_forw,
	input  exec_pkg::operand_t imm,
	input  exec_pkg::sel_t     sel_a,
	input  exec_pkg::sel_t     sel_b,
	output exec_pkg::operand_t operand_a,
	output exec_pkg::operand_t operand_b
);

	// Lane 0 is operand A, lane 1 is operand B
	exec_pkg::operand_t muxed [2];
	exec_pkg::operand_t opnd_q [2];
	logic               saved [2];

	////////////////////////////////////////////////////////////
	// Source muxes
	////////////////////////////////////////////////////////////
	// Operand A, immediate code falls back to the register file
	always_comb begin
		case (sel_a)
			exec_pkg::SEL_EX_FORW: muxed[0] = ex_forw;
			exec_pkg::SEL_WB_FORW: muxed[0] = wb_forw;
			default:               muxed[0] = rf_a;
		endcase
	end

	// Operand B
	always_comb begin
		case (sel_b)
			exec_pkg::SEL_IMM:     muxed[1] = imm;
			exec_pkg::SEL_EX_FORW: muxed[1] = ex_forw;
			exec_pkg::SEL_WB_FORW: muxed[1] = wb_forw;
			default:               muxed[1] = rf_b;
		endcase
	end

	////////////////////////////////////////////////////////////
	// Operand registers
	////////////////////////////////////////////////////////////
	for (genvar i = 0; i < 2; i++) begin : g_opnd
		always_ff @(posedge clk) begin
			if (!rst_n) begin
				opnd_q[i] <= '0;
				saved[i]  <= 1'b0;
			end else if (!ex_freeze && id_freeze && !saved[i]) begin
				// First frozen edge, keep this value
				opnd_q[i] <= muxed[i];
				saved[i]  <= 1'b1;
			end else if (!ex_freeze && !saved[i]) begin
				// Normal flow
				opnd_q[i] <= muxed[i];
			end else if (!ex_freeze && !id_freeze) begin
				// Release edge, hold value and drop the flag
				saved[i] <= 1'b0;
			end
		end
	end

	assign operand_a = opnd_q[0];
	assign operand_b = opnd_q[1];

endmodule

// ==== src/ex_stage.sv ====
////////////////////////////////////////////////////////////
// EX control, ALU and WB register. EX takes a bubble while
// ID is frozen and holds under ex_freeze. WB takes a bubble
// under ex_freeze so a held instruction retires once
////////////////////////////////////////////////////////////

module ex_stage (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               id_freeze,
	input  logic               ex_freeze,
	input  exec_pkg::issue_t   issue,
	input  exec_pkg::operand_t operand_a,
	input  exec_pkg::operand_t operand_b,
	output exec_pkg::operand_t ex_forw,
	output exec_pkg::ex_dst_t  ex_dst,
	output exec_pkg::wb_t      wb
);

	// EX control state
	exec_pkg::ex_dst_t ex_q;
	exec_pkg::alu_op_e ex_op;
	// Shift amount from operand B
	logic [exec_pkg::SHAMT_W-1:0] shamt;

	////////////////////////////////////////////////////////////
	// EX control registers
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ex_q  <= '0;
			ex_op <= exec_pkg::ALU_ADD;
		end else if (!ex_freeze) begin
			if (id_freeze) begin
				// Bubble while ID is held
				ex_q.valid <= 1'b0;
			end else begin
				ex_q.valid <= issue.valid;
				ex_q.rd    <= issue.rd;
				ex_op      <= issue.op;
			end
		end
	end

	// Destination seen by forwarding control
	assign ex_dst = ex_q;

	////////////////////////////////////////////////////////////
	// ALU
	////////////////////////////////////////////////////////////
	assign shamt = operand_b[exec_pkg::SHAMT_W-1:0];

	always_comb begin
		case (ex_op)
			exec_pkg::ALU_ADD: ex_forw = operand_a + operand_b;
			exec_pkg::ALU_SUB: ex_forw = operand_a - operand_b;
			exec_pkg::ALU_AND: ex_forw = operand_a & operand_b;
			exec_pkg::ALU_OR:  ex_forw = operand_a | operand_b;
			exec_pkg::ALU_XOR: ex_forw = operand_a ^ operand_b;
			// Logical shifts only
			exec_pkg::ALU_SLL: ex_forw = operand_a << shamt;
			exec_pkg::ALU_SRL: ex_forw = operand_a >> shamt;
			// Unused code gives zero
			default:           ex_forw = '0;
		endcase
	end

	////////////////////////////////////////////////////////////
	// WB register
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wb <= '0;
		end else if (ex_freeze) begin
			// EX is held, nothing new to retire
			wb.valid <= 1'b0;
		end else begin
			wb.valid <= ex_q.valid;
			wb.rd    <= ex_q.rd;
			wb.data  <= ex_forw;
		end
	end

endmodule

// ==== src/exec_core.sv ====
////////////////////////////////////////////////////////////
// Operand path top. One issue per cycle when both freezes
// are low. ex_freeze must only be raised with id_freeze.
// retire is the WB stage state
////////////////////////////////////////////////////////////

module exec_core (
	input  logic              clk,
	input  logic              rst_n,
	input  exec_pkg::issue_t  issue,
	input  logic              id_freeze,
	input  logic              ex_freeze,
	output exec_pkg::wb_t     retire
);

	////////////////////////////////////////////////////////////
	// Internal nets
	////////////////////////////////////////////////////////////
	// Register file read data
	exec_pkg::operand_t rf_a;
	exec_pkg::operand_t rf_b;
	// Forwarding selectors
	exec_pkg::sel_t     sel_a;
	exec_pkg::sel_t     sel_b;
	// EX operands and result
	exec_pkg::operand_t operand_a;
	exec_pkg::operand_t operand_b;
	exec_pkg::operand_t ex_forw;
	exec_pkg::ex_dst_t  ex_dst;

	// Register file, written from WB
	reg_file u_reg_file (
		.clk   (clk),
		.rst_n (rst_n),
		.ra    (issue.ra),
		.rb    (issue.rb),
		.rf_a  (rf_a),
		.rf_b  (rf_b),
		.wb    (retire)
	);

	// Source selection for ID
	fwd_ctrl u_fwd_ctrl (
		.issue  (issue),
		.ex_dst (ex_dst),
		.wb     (retire),
		.sel_a  (sel_a),
		.sel_b  (sel_b)
	);

	// Muxes and EX operand registers
	operand_muxes u_operand_muxes (
		.clk       (clk),
		.rst_n     (rst_n),
		.id_freeze (id_freeze),
		.ex_freeze (ex_freeze),
		.rf_a      (rf_a),
		.rf_b      (rf_b),
		.ex_forw   (ex_forw),
		.wb_forw   (retire.data),
		.imm       (issue.imm),
		.sel_a     (sel_a),
		.sel_b     (sel_b),
		.operand_a (operand_a),
		.operand_b (operand_b)
	);

	// EX and WB stages
	ex_stage u_ex_stage (
		.clk       (clk),
		.rst_n     (rst_n),
		.id_freeze (id_freeze),
		.ex_freeze (ex_freeze),
		.issue     (issue),
		.operand_a (operand_a),
		.operand_b (operand_b),
		.ex_forw   (ex_forw),
		.ex_dst    (ex_dst),
		.wb        (retire)
	);

endmodule

// ==== dv/exec_core_sva.sv ====
////////////////////////////////////////////////////////////
// Protocol checks bound into exec_core. Sees the internal
// EX operand B through the bind port list
////////////////////////////////////////////////////////////

module exec_core_sva (
	input logic               clk,
	input logic               rst_n,
	input logic               id_freeze,
	input logic               ex_freeze,
	input logic               use_imm,
	input exec_pkg::operand_t imm,
	input exec_pkg::operand_t operand_b,
	input logic               retire_valid
);

	timeunit 1ns;
	timeprecision 100ps;

	// EX may only stall together with ID
	a_freeze_order: assert property (@(posedge clk) disable iff (!rst_n)
		ex_freeze |-> id_freeze) else $error("ex_freeze high without id_freeze");

	// Accepted immediate instruction enters EX with its immediate as operand B
	a_imm_sel: assert property (@(posedge clk) disable iff (!rst_n)
		(use_imm && !id_freeze && !ex_freeze) |=> (operand_b == $past(imm)))
		else $error("operand B is not the immediate of the accepted instruction");

	// Nothing retires right out of reset
	a_reset_quiet: assert property (@(posedge clk)
		$rose(rst_n) |-> !retire_valid) else $error("retire valid after reset");

endmodule

bind exec_core exec_core_sva u_sva (
	.clk          (clk),
	.rst_n        (rst_n),
	.id_freeze    (id_freeze),
	.ex_freeze    (ex_freeze),
	.use_imm      (issue.use_imm),
	.imm          (issue.imm),
	.operand_b    (operand_b),
	.retire_valid (retire.valid)
);

// ==== dv/tb_exec_core.sv ====
////////////////////////////////////////////////////////////
// Testbench for exec_core. Reads dv/exec_cases.txt from the
// project root, issues each line in order and checks every
// retire against the expected rd, data and latency
////////////////////////////////////////////////////////////

module tb_exec_core;

	timeunit 1ns;
	timeprecision 100ps;

	logic               clk;
	logic               rst_n;
	exec_pkg::issue_t   issue;
	logic               id_freeze;
	logic               ex_freeze;
	exec_pkg::wb_t      retire;

	// Case table loaded from the file
	int                 c_op[$];
	int                 c_rd[$];
	int                 c_ra[$];
	int                 c_rb[$];
	int                 c_imm_en[$];
	logic [31:0]        c_imm[$];
	int                 c_ids[$];
	int                 c_exs[$];
	int                 c_exp_rd[$];
	logic [31:0]        c_exp_data[$];
	int                 n_cases = 0;
	int                 max_stall = 0;
	bit                 loaded = 0;

	// Edge bookkeeping for the latency check
	int                 edge_cnt = 0;
	int                 exf_cnt = 0;
	int                 acc_edge[$];
	int                 acc_exf[$];
	int                 ret_idx = 0;
	int                 value_errs = 0;
	int                 other_errs = 0;

	exec_core dut (
		.clk       (clk),
		.rst_n     (rst_n),
		.issue     (issue),
		.id_freeze (id_freeze),
		.ex_freeze (ex_freeze),
		.retire    (retire)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	////////////////////////////////////////////////////////////
	// Acceptance tracking and retire checks
	////////////////////////////////////////////////////////////
	// Counts edges, ex-frozen edges and accepted issues
	always @(posedge clk) begin
		edge_cnt++;
		if (rst_n && ex_freeze)
			exf_cnt++;
		if (rst_n && issue.valid && !id_freeze && !ex_freeze) begin
			acc_edge.push_back(edge_cnt);
			acc_exf.push_back(exf_cnt);
		end
	end

	// Retire sampled mid-cycle where it is stable
	always @(negedge clk) begin
		int a_edge;
		int a_exf;
		if (rst_n && retire.valid) begin
			if (acc_edge.size() == 0 || ret_idx >= n_cases) begin
				$display("Retire at %0t with no instruction outstanding", $time);
				other_errs++;
			end else begin
				a_edge = acc_edge.pop_front();
				a_exf = acc_exf.pop_front();
				assert (retire.rd == exec_pkg::reg_idx_t'(c_exp_rd[ret_idx])) else begin
					$display("Error: %0t retire.rd expected %0d got %0d",
						$time, c_exp_rd[ret_idx], retire.rd);
					value_errs++;
				end
				assert (retire.data == c_exp_data[ret_idx]) else begin
					$display("Error: %0t retire.data expected %h got %h",
						$time, c_exp_data[ret_idx], retire.data);
					value_errs++;
				end
				// One edge into WB, plus each edge EX was held
				assert (edge_cnt - a_edge == 1 + exf_cnt - a_exf) else begin
					$display("Error: %0t retire latency expected %0d got %0d",
						$time, 1 + exf_cnt - a_exf, edge_cnt - a_edge);
					value_errs++;
				end
				ret_idx++;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////
	task automatic load_cases();
		int fd;
		int n;
		string line;
		int op;
		int rd;
		int ra;
		int rb;
		int ie;
		int ids;
		int exs;
		int erd;
		logic [31:0] imm;
		logic [31:0] edata;
		fd = $fopen("dv/exec_cases.txt", "r");
		if (fd == 0) begin
			$display("Could not open the cases file");
			other_errs++;
			return;
		end
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			// Skip blank and comment lines
			if (line.len() < 2 || line.substr(0, 0) == "#")
				continue;
			n = $sscanf(line, "%d %d %d %d %d %h %d %d %d %h",
				op, rd, ra, rb, ie, imm, ids, exs, erd, edata);
			if (n != 10) begin
				$display("Malformed line in the cases file");
				other_errs++;
				continue;
			end
			c_op.push_back(op);
			c_rd.push_back(rd);
			c_ra.push_back(ra);
			c_rb.push_back(rb);
			c_imm_en.push_back(ie);
			c_imm.push_back(imm);
			c_ids.push_back(ids);
			c_exs.push_back(exs);
			c_exp_rd.push_back(erd);
			c_exp_data.push_back(edata);
			if (ids + exs > max_stall)
				max_stall = ids + exs;
		end
		$fclose(fd);
		n_cases = c_op.size();
	endtask

	// True when an idle gap after case k would move a dependent
	// case out of EX or WB bypass range
	function automatic bit gap_breaks_bypass(input int k);
		bit hit;
		hit = 1'b0;
		for (int m = k + 1; m <= k + 2; m++) begin
			for (int j = m - 2; j <= k; j++) begin
				if (m < n_cases && j >= 0) begin
					if (c_ra[m] == c_rd[j])
						hit = 1'b1;
					if (c_imm_en[m] == 0 && c_rb[m] == c_rd[j])
						hit = 1'b1;
				end
			end
		end
		return hit;
	endfunction

	// ID stall first, then EX stall, then the accepting edge
	task automatic issue_case(input int k);
		exec_pkg::issue_t w;
		w.valid = 1'b1;
		w.op = exec_pkg::alu_op_e'(3'(c_op[k]));
		w.rd = exec_pkg::reg_idx_t'(c_rd[k]);
		w.ra = exec_pkg::reg_idx_t'(c_ra[k]);
		w.rb = exec_pkg::reg_idx_t'(c_rb[k]);
		w.use_imm = (c_imm_en[k] != 0);
		w.imm = c_imm[k];
		for (int i = 0; i < c_ids[k]; i++) begin
			@(posedge clk);
			issue <= w;
			id_freeze <= 1'b1;
			ex_freeze <= 1'b0;
		end
		for (int i = 0; i < c_exs[k]; i++) begin
			@(posedge clk);
			issue <= w;
			id_freeze <= 1'b1;
			ex_freeze <= 1'b1;
		end
		@(posedge clk);
		issue <= w;
		id_freeze <= 1'b0;
		ex_freeze <= 1'b0;
	endtask

	initial begin
		int gap;
		issue = '0;
		id_freeze = 1'b0;
		ex_freeze = 1'b0;
		rst_n = 1'b0;
		void'($urandom(32'hfc26));
		load_cases();
		loaded = 1;
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
		// A few idle cycles, nothing may retire here
		repeat (3) @(posedge clk);
		for (int k = 0; k < n_cases; k++) begin
			issue_case(k);
			gap = $urandom % 3;
			// Dependent neighbours stay at their bypass distance
			if (gap_breaks_bypass(k))
				gap = 0;
			for (int g = 0; g < gap; g++) begin
				@(posedge clk);
				issue <= '0;
			end
		end
		@(posedge clk);
		issue <= '0;
		wait (ret_idx >= n_cases);
		// Catch any duplicate retire
		repeat (5) @(posedge clk);
		@(negedge clk);
		$display("Error counts: %0d value, %0d other", value_errs, other_errs);
		if (value_errs == 0 && other_errs == 0 && n_cases > 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

	// Watchdog sized from the case count and longest stall
	initial begin
		int limit;
		wait (loaded);
		limit = (n_cases * (max_stall + 5) + 20) * 20;
		#(limit);
		$display("Run timed out after %0d ns with %0d of %0d retired",
			limit, ret_idx, n_cases);
		$display("tests failed");
		$finish;
	end

endmodule

// ==== dv/exec_cases.txt ====
# op(0 add 1 sub 2 and 3 or 4 xor 5 sll 6 srl) rd ra rb use_imm imm(hex)
# id_stall ex_stall exp_rd exp_data(hex)
0 1 2 0 1 00000005 0 0 1 00000005
0 2 1 0 1 00000010 0 0 2 00000015
0 3 1 2 0 00000000 0 0 3 0000001a
1 4 3 1 0 00000000 0 0 4 00000015
2 5 3 2 0 00000000 0 0 5 00000010
3 6 5 4 0 00000000 0 0 6 00000015
4 7 6 0 1 000000ff 0 0 7 000000ea
5 8 7 0 1 00000004 0 0 8 00000ea0
6 9 8 1 0 00000000 0 0 9 00000075
1 10 0 1 0 00000000 0 0 10 fffffffb
6 11 10 0 1 00000024 0 0 11 0fffffff
5 12 1 0 1 0000001f 0 0 12 80000000
0 0 1 0 1 00000123 0 0 0 00000128
0 13 0 0 0 00000000 0 0 13 00000000
0 14 0 1 0 00000000 0 0 14 00000005
0 15 15 0 1 00000001 0 0 15 00000001
0 15 15 0 1 00000002 0 0 15 00000003
0 16 15 15 0 00000000 0 0 16 00000006
0 17 2 16 0 00000000 0 0 17 0000001b
1 18 16 17 0 00000000 0 0 18 ffffffeb
0 20 18 0 1 00000020 3 0 20 0000000b
4 21 20 17 0 00000000 2 0 21 00000010
0 22 21 21 0 00000000 0 3 22 00000020
1 23 22 0 1 00000001 2 2 23 0000001f
3 24 23 22 0 00000000 1 1 24 0000003f
2 25 24 0 1 000000f0 0 1 25 00000030
5 26 25 1 0 00000000 4 0 26 00000600
6 27 26 0 1 00000003 0 0 27 000000c0
0 28 27 26 0 00000000 0 0 28 000006c0
1 29 28 27 0 00000000 1 0 29 00000600
4 30 29 0 1 00000abc 0 0 30 00000cbc
0 31 30 9 0 00000000 0 0 31 00000d31
0 0 31 0 1 00000001 2 0 0 00000d32
3 1 0 0 0 00000000 0 0 1 00000000
0 2 1 0 1 00000007 0 0 2 00000007
1 3 2 31 0 00000000 0 2 3 fffff2d6

// ==== vlog.f ====
src/exec_pkg.sv
src/reg_file.sv
src/fwd_ctrl.sv
src/operand_muxes.sv
src/ex_stage.sv
src/exec_core.sv
dv/exec_core_sva.sv
dv/tb_exec_core.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the exec_core testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert --timing \
	--timescale 1ns/100ps \
	--top-module tb_exec_core \
	-f vlog.f

./obj_dir/Vtb_exec_core | tee sim.log

if grep -q "^all tests passed$" sim.log; then
	echo "Simulation result: PASS"
	exit 0
else
	echo "Simulation result: FAIL"
	exit 1
fi
